// ==== Bender.yml ====
package:
  name: sprite_engine

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/sprite_pkg.sv
      - rtl/sprite_attr_decode.sv
      - rtl/sprite_pixel_writer.sv
      - rtl/sprite_line_output.sv
      - rtl/sprite_engine.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/sprite_mem_models.sv
      - verification/sprite_engine_tb.sv

// ==== rtl/sprite_attr_decode.sv ====
`timescale 1ns/100ps
`include "sprite_config.svh"

module sprite_attr_decode (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       hsync,
	input  logic [`SPR_POS_W-1:0]      vcnt,
	input  logic                       table_ready,
	input  sprite_pkg::spr_byte_u      spriteram_data,
	input  logic                       sprite_done,
	output logic [`SPR_RAM_W-1:0]      spriteram_addr,
	output logic                       sprite_start,
	output sprite_pkg::sprite_desc_t   sprite_desc,
	output logic                       wr_slot,
	output logic                       rd_slot
);
	import sprite_pkg::*;

	localparam int IDX_W = $clog2(`SPR_COUNT);
	localparam int Y_W = `SPR_POS_W + 1;

	dec_state_t            state;
	dec_state_t            state_next;
	logic                  hsync_last;
	logic                  hsync_rise;
	logic [IDX_W-1:0]      spr_index;
	logic                  outstanding;
	logic [`SPR_POS_W-1:0] active_y;
	spr_attr_t             attr;
	logic [`SPR_POS_W-1:0] spr_y;
	logic [Y_W-1:0]        size_m1;
	logic [Y_W-1:0]        y_last;
	logic                  y_hit;

	assign hsync_rise = hsync && !hsync_last;

	// Read slot is always the other half of the buffer
	assign rd_slot = ~wr_slot;

	// Height minus one, empty sprites are rejected below
	always_comb
	begin
		case (attr.size)
			SIZE_32: size_m1 = Y_W'(31);
			SIZE_16: size_m1 = Y_W'(15);
			default: size_m1 = Y_W'(7);
		endcase
	end

	// Extra bit keeps the bottom edge from wrapping near 511
	assign y_last = {1'b0, spr_y} + size_m1;
	assign y_hit = attr.enable && (attr.size != SIZE_NONE) &&
		(active_y >= spr_y) && ({1'b0, active_y} <= y_last);

	always_ff @(posedge clk)
	begin
		sprite_start <= 1'b0;
		if (reset)
		begin
			state <= DEC_IDLE;
			state_next <= DEC_IDLE;
			hsync_last <= 1'b0;
			wr_slot <= 1'b1;
			outstanding <= 1'b0;
			spr_index <= '0;
			spriteram_addr <= '0;
		end
		else
		begin
			hsync_last <= hsync;

			// Track the sprite the writer is still working on
			if (sprite_start)
			begin
				outstanding <= 1'b1;
			end
			else if (sprite_done)
			begin
				outstanding <= 1'b0;
			end

			// New line: swap slots and restart the scan from record 0
			if (hsync_rise && table_ready)
			begin
				wr_slot <= ~wr_slot;
				if (vcnt == `SPR_VCNT_WRAP)
				begin
					active_y <= `SPR_BORDER;
				end
				else
				begin
					active_y <= `SPR_POS_W'(vcnt + `SPR_BORDER + 1);
				end
				spr_index <= '0;
				spriteram_addr <= '0;
				state <= DEC_WAIT;
				state_next <= DEC_ATTR;
			end
			else
			begin
				case (state)
					// One idle cycle per RAM read
					DEC_WAIT:
					begin
						state <= state_next;
					end
					DEC_ATTR:
					begin
						attr <= spriteram_data.attr;
						spriteram_addr <= spriteram_addr + 1'b1;
						state <= DEC_WAIT;
						state_next <= DEC_Y;
					end
					DEC_Y:
					begin
						spr_y <= {attr.y8, spriteram_data};
						state <= DEC_CHECK;
					end
					DEC_CHECK:
					begin
						if (y_hit)
						begin
							spriteram_addr <= spriteram_addr + 1'b1;
							state <= DEC_WAIT;
							state_next <= DEC_XHI;
						end
						else
						begin
							state <= DEC_NEXT;
						end
					end
					DEC_XHI:
					begin
						sprite_desc.image <= spriteram_data.xhi.image;
						sprite_desc.x[`SPR_POS_W-1] <= spriteram_data.xhi.x8;
						spriteram_addr <= spriteram_addr + 1'b1;
						state <= DEC_WAIT;
						state_next <= DEC_XLO;
					end
					DEC_XLO:
					begin
						sprite_desc.x[`SPR_POS_W-2:0] <= spriteram_data;
						sprite_desc.line <= active_y - spr_y;
						sprite_desc.palette <= attr.palette;
						sprite_desc.size <= attr.size;
						sprite_desc.mirror <= attr.mirror;
						sprite_desc.spare <= 1'b0;
						state <= DEC_START;
					end
					// Hold off while a sprite from an aborted line drains
					DEC_START:
					begin
						if (!outstanding)
						begin
							sprite_start <= 1'b1;
							state <= DEC_BUSY;
						end
					end
					DEC_BUSY:
					begin
						if (sprite_done)
						begin
							state <= DEC_NEXT;
						end
					end
					DEC_NEXT:
					begin
						if (spr_index == IDX_W'(`SPR_COUNT - 1))
						begin
							state <= DEC_IDLE;
						end
						else
						begin
							spr_index <= spr_index + 1'b1;
							spriteram_addr <=
								`SPR_RAM_W'((spr_index + 1'b1) * `SPR_REC_BYTES);
							state <= DEC_WAIT;
							state_next <= DEC_ATTR;
						end
					end
					default:
					begin
						state <= DEC_IDLE;
					end
				endcase
			end
		end
	end

	// Only one sprite in flight between decode and the writer
	a_one_outstanding: assert property (@(posedge clk) disable iff (reset)
		sprite_start |=> (!sprite_start until sprite_done));

endmodule

// ==== rtl/sprite_config.svh ====
`ifndef SPRITE_CONFIG_SVH
`define SPRITE_CONFIG_SVH

// Width of screen positions, sprite coordinates and line counters
`define SPR_POS_W 9

// Sprite ROM address width, three offset bytes hold 17 bits
`define SPR_ROM_W 17

// Sprite RAM address width, 32 records of 4 bytes
`define SPR_RAM_W 7

// Number of sprite records scanned per line
`define SPR_COUNT 32

// Off-screen border added to both beam counters
`define SPR_BORDER 32

// Last vcnt of a frame, the line after it is the first border line
`define SPR_VCNT_WRAP 255

// Record layout in sprite RAM
// Byte 0 attributes and y8, byte 1 y low, byte 2 image and x8, byte 3 x low
`define SPR_REC_BYTES 4

// Offset table at the start of sprite ROM
// 32x32, 16x16 then 8x8, three bytes each with the high byte first
`define SPR_TABLE_BYTES 9

`endif

// ==== rtl/sprite_engine.sv ====
`timescale 1ns/100ps
`include "sprite_config.svh"

module sprite_engine (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   hsync,
	input  logic [`SPR_POS_W-1:0]  vcnt,
	input  logic [`SPR_POS_W-1:0]  hcnt,
	input  logic [7:0]             spriteram_data,
	input  logic [7:0]             sprom_data,
	input  sprite_pkg::lb_pixel_t  palrom_data,
	input  sprite_pkg::lb_pixel_t  lb_rd_data,
	output logic [`SPR_RAM_W-1:0]  spriteram_addr,
	output logic [`SPR_ROM_W-1:0]  sprom_addr,
	output logic [7:0]             palrom_addr,
	output logic [`SPR_POS_W:0]    lb_rd_addr,
	output logic [`SPR_POS_W:0]    lb_wr_addr,
	output logic                   lb_wr,
	output sprite_pkg::lb_pixel_t  lb_wr_data,
	output logic                   lb_rd_wr,
	output sprite_pkg::rgb_t       pixel_out
);
	import sprite_pkg::*;

	// Decode to writer
	logic         sprite_start;
	logic         sprite_done;
	logic         table_ready;
	sprite_desc_t sprite_desc;

	// Line buffer halves
	logic wr_slot;
	logic rd_slot;

	sprite_attr_decode sprite_attr_decode_inst (
		.clk            (clk),
		.reset          (reset),
		.hsync          (hsync),
		.vcnt           (vcnt),
		.table_ready    (table_ready),
		.spriteram_data (spriteram_data),
		.sprite_done    (sprite_done),
		.spriteram_addr (spriteram_addr),
		.sprite_start   (sprite_start),
		.sprite_desc    (sprite_desc),
		.wr_slot        (wr_slot),
		.rd_slot        (rd_slot)
	);

	sprite_pixel_writer sprite_pixel_writer_inst (
		.clk          (clk),
		.reset        (reset),
		.sprom_data   (sprom_data),
		.palrom_data  (palrom_data),
		.sprite_start (sprite_start),
		.sprite_desc  (sprite_desc),
		.wr_slot      (wr_slot),
		.sprom_addr   (sprom_addr),
		.palrom_addr  (palrom_addr),
		.lb_wr        (lb_wr),
		.lb_wr_addr   (lb_wr_addr),
		.lb_wr_data   (lb_wr_data),
		.sprite_done  (sprite_done),
		.table_ready  (table_ready)
	);

	sprite_line_output sprite_line_output_inst (
		.clk        (clk),
		.reset      (reset),
		.hcnt       (hcnt),
		.rd_slot    (rd_slot),
		.lb_rd_data (lb_rd_data),
		.lb_rd_addr (lb_rd_addr),
		.lb_rd_wr   (lb_rd_wr),
		.pixel_out  (pixel_out)
	);

endmodule

// ==== rtl/sprite_line_output.sv ====
`timescale 1ns/100ps
`include "sprite_config.svh"

module sprite_line_output (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [`SPR_POS_W-1:0]  hcnt,
	input  logic                   rd_slot,
	input  sprite_pkg::lb_pixel_t  lb_rd_data,
	output logic [`SPR_POS_W:0]    lb_rd_addr,
	output logic                   lb_rd_wr,
	output sprite_pkg::rgb_t       pixel_out
);
	import sprite_pkg::*;

	logic [1:0] phase;

	// Buffer column follows the beam, shifted past the border
	assign lb_rd_addr = {rd_slot, `SPR_POS_W'(hcnt + `SPR_BORDER)};

	// One pixel per four clocks
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase <= 2'd0;
			lb_rd_wr <= 1'b0;
		end
		else
		begin
			phase <= phase + 2'd1;
			// Clears the entry just read so the slot is empty for the next line
			lb_rd_wr <= (phase == 2'd0);
		end
	end

	// 5 to 8 bits by repeating the top 3 bits
	always_ff @(posedge clk)
	begin
		if (phase == 2'd0)
		begin
			pixel_out.r <= {lb_rd_data.red, lb_rd_data.red[4:2]};
			pixel_out.g <= {lb_rd_data.green, lb_rd_data.green[4:2]};
			pixel_out.b <= {lb_rd_data.blue, lb_rd_data.blue[4:2]};
			pixel_out.a <= lb_rd_data.alpha;
		end
	end

endmodule

// ==== rtl/sprite_pixel_writer.sv ====
`timescale 1ns/100ps
`include "sprite_config.svh"

module sprite_pixel_writer (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [7:0]                 sprom_data,
	input  sprite_pkg::lb_pixel_t      palrom_data,
	input  logic                       sprite_start,
	input  sprite_pkg::sprite_desc_t   sprite_desc,
	input  logic                       wr_slot,
	output logic [`SPR_ROM_W-1:0]      sprom_addr,
	output logic [7:0]                 palrom_addr,
	output logic                       lb_wr,
	output logic [`SPR_POS_W:0]        lb_wr_addr,
	output sprite_pkg::lb_pixel_t      lb_wr_data,
	output logic                       sprite_done,
	output logic                       table_ready
);
	import sprite_pkg::*;

	localparam int TBL_W = 8 * `SPR_TABLE_BYTES;
	localparam int CNT_W = $clog2(`SPR_TABLE_BYTES);

	wr_state_t             state;
	logic [CNT_W-1:0]      tbl_cnt;
	logic [TBL_W-1:0]      tbl_bytes;
	logic [`SPR_ROM_W-1:0] off_32;
	logic [`SPR_ROM_W-1:0] off_16;
	logic [`SPR_ROM_W-1:0] off_8;
	logic [`SPR_ROM_W-1:0] size_off;
	logic [`SPR_ROM_W-1:0] img_term;
	logic [`SPR_ROM_W-1:0] row_term;
	logic [`SPR_ROM_W-1:0] start_addr;
	logic [4:0]            last_px_init;
	logic [4:0]            last_px;
	logic [4:0]            px_idx;
	logic                  px_last;
	logic                  mirror;
	logic [1:0]            palette;

	// Table bytes shift in from the bottom, so the 32x32 entry ends up on top
	assign off_32 = tbl_bytes[TBL_W-24 +: `SPR_ROM_W];
	assign off_16 = tbl_bytes[TBL_W-48 +: `SPR_ROM_W];
	assign off_8  = tbl_bytes[0 +: `SPR_ROM_W];

	// First ROM byte of the sprite row
	always_comb
	begin
		case (sprite_desc.size)
			SIZE_32:
			begin
				size_off = off_32;
				img_term = `SPR_ROM_W'(sprite_desc.image) << 10;
				row_term = `SPR_ROM_W'(sprite_desc.line[4:0]) << 5;
				last_px_init = 5'd31;
			end
			SIZE_16:
			begin
				size_off = off_16;
				img_term = `SPR_ROM_W'(sprite_desc.image) << 8;
				row_term = `SPR_ROM_W'(sprite_desc.line[3:0]) << 4;
				last_px_init = 5'd15;
			end
			default:
			begin
				size_off = off_8;
				img_term = `SPR_ROM_W'(sprite_desc.image) << 6;
				row_term = `SPR_ROM_W'(sprite_desc.line[2:0]) << 3;
				last_px_init = 5'd7;
			end
		endcase
		// Mirrored rows are walked from their right end
		start_addr = size_off + img_term + row_term +
			(sprite_desc.mirror ? `SPR_ROM_W'(last_px_init) : '0);
	end

	assign px_last = (px_idx == last_px);

	always_ff @(posedge clk)
	begin
		sprite_done <= 1'b0;
		if (reset)
		begin
			state <= WR_LOAD_WAIT;
			sprom_addr <= '0;
			tbl_cnt <= '0;
			table_ready <= 1'b0;
			lb_wr <= 1'b0;
		end
		else
		begin
			case (state)
				WR_LOAD_WAIT:
				begin
					state <= WR_LOAD_BYTE;
				end
				WR_LOAD_BYTE:
				begin
					tbl_bytes <= {tbl_bytes[TBL_W-9:0], sprom_data};
					if (tbl_cnt == CNT_W'(`SPR_TABLE_BYTES - 1))
					begin
						table_ready <= 1'b1;
						state <= WR_IDLE;
					end
					else
					begin
						tbl_cnt <= tbl_cnt + 1'b1;
						sprom_addr <= sprom_addr + 1'b1;
						state <= WR_LOAD_WAIT;
					end
				end
				WR_IDLE:
				begin
					if (sprite_start)
					begin
						// Empty size code has nothing to draw
						if (sprite_desc.size == SIZE_NONE)
						begin
							sprite_done <= 1'b1;
						end
						else
						begin
							sprom_addr <= start_addr;
							lb_wr_addr <= {wr_slot, sprite_desc.x};
							mirror <= sprite_desc.mirror;
							palette <= sprite_desc.palette;
							last_px <= last_px_init;
							px_idx <= '0;
							state <= WR_FETCH_WAIT;
						end
					end
				end
				WR_FETCH_WAIT:
				begin
					state <= WR_GET;
				end
				// Colour index to palette, step ROM to the next pixel
				WR_GET:
				begin
					palrom_addr <= {palette, sprom_data[4:0], 1'b0};
					sprom_addr <= mirror ? sprom_addr - 1'b1 : sprom_addr + 1'b1;
					state <= WR_PAL_WAIT;
				end
				WR_PAL_WAIT:
				begin
					state <= WR_STAGE;
				end
				WR_STAGE:
				begin
					if (palrom_data.alpha)
					begin
						lb_wr <= 1'b1;
						lb_wr_data <= palrom_data;
						state <= WR_WRITE;
					end
					else
					begin
						// Transparent, skip the write cycle
						lb_wr_addr[`SPR_POS_W-1:0] <= lb_wr_addr[`SPR_POS_W-1:0] + 1'b1;
						px_idx <= px_idx + 1'b1;
						sprite_done <= px_last;
						state <= px_last ? WR_IDLE : WR_GET;
					end
				end
				WR_WRITE:
				begin
					lb_wr <= 1'b0;
					lb_wr_addr[`SPR_POS_W-1:0] <= lb_wr_addr[`SPR_POS_W-1:0] + 1'b1;
					px_idx <= px_idx + 1'b1;
					sprite_done <= px_last;
					state <= px_last ? WR_IDLE : WR_GET;
				end
				default:
				begin
					state <= WR_IDLE;
				end
			endcase
		end
	end

	// A new sprite only arrives while the writer is idle
	a_start_when_idle: assert property (@(posedge clk) disable iff (reset)
		sprite_start |-> (state == WR_IDLE));

endmodule

// ==== rtl/sprite_pkg.sv ====
`include "sprite_config.svh"

package sprite_pkg;

	// Sprite size as encoded in the attribute byte
	typedef enum logic [1:0] {
		SIZE_32   = 2'd0,
		SIZE_16   = 2'd1,
		SIZE_8    = 2'd2,
		SIZE_NONE = 2'd3
	} size_code_t;

	// Byte 0 of a record
	typedef struct packed {
		logic       enable;
		logic       collide;   // no collision logic here, bit is ignored
		logic [1:0] palette;
		size_code_t size;
		logic       mirror;
		logic       y8;
	} spr_attr_t;

	// Byte 2 of a record
	typedef struct packed {
		logic [6:0] image;
		logic       x8;
	} spr_xhi_t;

	// One sprite RAM byte, seen as attributes or as X high
	typedef union packed {
		spr_attr_t attr;
		spr_xhi_t  xhi;
	} spr_byte_u;

	// Sprite handed from decode to the pixel writer
	typedef struct packed {
		logic [`SPR_POS_W-1:0] x;
		logic [`SPR_POS_W-1:0] line;
		logic [6:0]            image;
		logic [1:0]            palette;
		size_code_t            size;
		logic                  mirror;
		logic                  spare;
	} sprite_desc_t;

	// Line buffer and palette word, alpha set means opaque
	typedef struct packed {
		logic       alpha;
		logic [4:0] blue;
		logic [4:0] green;
		logic [4:0] red;
	} lb_pixel_t;

	// Expanded output colour
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		logic       a;
	} rgb_t;

	// Record scan FSM
	typedef enum logic [3:0] {
		DEC_IDLE,
		DEC_WAIT,
		DEC_ATTR,
		DEC_Y,
		DEC_CHECK,
		DEC_XHI,
		DEC_XLO,
		DEC_START,
		DEC_BUSY,
		DEC_NEXT
	} dec_state_t;

	// Offset load and pixel FSM
	typedef enum logic [2:0] {
		WR_LOAD_WAIT,
		WR_LOAD_BYTE,
		WR_IDLE,
		WR_FETCH_WAIT,
		WR_GET,
		WR_PAL_WAIT,
		WR_STAGE,
		WR_WRITE
	} wr_state_t;

endpackage

// ==== src.f ====
+incdir+rtl
rtl/sprite_pkg.sv
rtl/sprite_attr_decode.sv
rtl/sprite_pixel_writer.sv
rtl/sprite_line_output.sv
rtl/sprite_engine.sv
verification/sprite_mem_models.sv
verification/sprite_engine_tb.sv

// ==== verification/sprite_engine_tb.sv ====
`timescale 1ns/100ps
`include "sprite_config.svh"

module sprite_engine_tb;
	import sprite_pkg::*;

	localparam int TIMEOUT = 4000;
	localparam int NUM_ROWS = 5;
	localparam logic [`SPR_ROM_W-1:0] OFF_32 = 17'h00400;
	localparam logic [`SPR_ROM_W-1:0] OFF_16 = 17'h08000;
	localparam logic [`SPR_ROM_W-1:0] OFF_8 = 17'h0c000;

	// One sprite record
	typedef struct packed {
		logic [4:0]            slot;
		logic                  enable;
		size_code_t            size;
		logic                  mirror;
		logic [1:0]            palette;
		logic [`SPR_POS_W-1:0] y;
		logic [`SPR_POS_W-1:0] x;
		logic [6:0]            image;
	} spr_rec_t;

	// Scenario row, two records per line
	typedef struct {
		string                 name;
		logic [`SPR_POS_W-1:0] vcnt;
		logic [`SPR_POS_W-1:0] hcnt;
		spr_rec_t              spr_a;
		spr_rec_t              spr_b;
	} scen_t;

	// Line buffer write as seen on the bus
	typedef struct packed {
		logic [`SPR_POS_W:0] addr;
		lb_pixel_t           pix;
	} lb_write_t;

	logic                  clk;
	logic                  reset;
	logic                  hsync;
	logic [`SPR_POS_W-1:0] vcnt;
	logic [`SPR_POS_W-1:0] hcnt;
	logic [7:0]            spriteram_data;
	logic [7:0]            sprom_data;
	lb_pixel_t             palrom_data;
	lb_pixel_t             lb_rd_data;
	logic [`SPR_RAM_W-1:0] spriteram_addr;
	logic [`SPR_ROM_W-1:0] sprom_addr;
	logic [7:0]            palrom_addr;
	logic [`SPR_POS_W:0]   lb_rd_addr;
	logic [`SPR_POS_W:0]   lb_wr_addr;
	logic                  lb_wr;
	lb_pixel_t             lb_wr_data;
	logic                  lb_rd_wr;
	rgb_t                  pixel_out;

	scen_t                 table_rows [NUM_ROWS];
	lb_write_t             got_writes [$];
	lb_write_t             exp_writes [$];
	logic [`SPR_ROM_W-1:0] got_fetch [$];
	logic [`SPR_ROM_W-1:0] exp_fetch [$];
	logic                  fetch_pending;
	logic                  exp_wr_slot;
	logic [31:0]           lcg_state;
	int                    error_count;
	int                    r;

	sprite_engine sprite_engine_inst (
		.clk            (clk),
		.reset          (reset),
		.hsync          (hsync),
		.vcnt           (vcnt),
		.hcnt           (hcnt),
		.spriteram_data (spriteram_data),
		.sprom_data     (sprom_data),
		.palrom_data    (palrom_data),
		.lb_rd_data     (lb_rd_data),
		.spriteram_addr (spriteram_addr),
		.sprom_addr     (sprom_addr),
		.palrom_addr    (palrom_addr),
		.lb_rd_addr     (lb_rd_addr),
		.lb_wr_addr     (lb_wr_addr),
		.lb_wr          (lb_wr),
		.lb_wr_data     (lb_wr_data),
		.lb_rd_wr       (lb_rd_wr),
		.pixel_out      (pixel_out)
	);

	sprite_mem_models mem_models_inst (
		.clk            (clk),
		.spriteram_addr (spriteram_addr),
		.spriteram_data (spriteram_data),
		.sprom_addr     (sprom_addr),
		.sprom_data     (sprom_data),
		.palrom_addr    (palrom_addr),
		.palrom_data    (palrom_data),
		.lb_rd_addr     (lb_rd_addr),
		.lb_rd_wr       (lb_rd_wr),
		.lb_rd_data     (lb_rd_data),
		.lb_wr_addr     (lb_wr_addr),
		.lb_wr          (lb_wr),
		.lb_wr_data     (lb_wr_data)
	);

	// 8 ns clock
	always #4 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// 5 bit channel to 8 bits, top 3 bits repeated
	function automatic rgb_t expand_colour(input lb_pixel_t p);
		rgb_t c;
		c.r = {p.red, p.red[4:2]};
		c.g = {p.green, p.green[4:2]};
		c.b = {p.blue, p.blue[4:2]};
		c.a = p.alpha;
		return c;
	endfunction

	task automatic report_error(input string msg);
		error_count++;
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_pixel(input string name, input logic [`SPR_POS_W:0] exp_addr,
		input lb_pixel_t exp_pix, input logic [`SPR_POS_W:0] act_addr,
		input lb_pixel_t act_pix);
		if (act_addr !== exp_addr || act_pix !== exp_pix)
		begin
			report_error($sformatf("mismatch %s: expected %h:%h, actual %h:%h",
				name, exp_addr, exp_pix, act_addr, act_pix));
		end
	endtask

	task automatic check_rgb(input string name, input rgb_t exp_rgb, input rgb_t act_rgb);
		if (act_rgb !== exp_rgb)
		begin
			report_error($sformatf("mismatch %s: expected %h, actual %h",
				name, exp_rgb, act_rgb));
		end
	endtask

	task automatic check_addr(input string name, input logic [`SPR_ROM_W-1:0] exp_addr,
		input logic [`SPR_ROM_W-1:0] act_addr);
		if (act_addr !== exp_addr)
		begin
			report_error($sformatf("mismatch %s: expected %h, actual %h",
				name, exp_addr, act_addr));
		end
	endtask

	task automatic check_count(input string name, input int exp_cnt, input int act_cnt);
		if (act_cnt != exp_cnt)
		begin
			report_error($sformatf("mismatch %s: expected %0d, actual %0d",
				name, exp_cnt, act_cnt));
		end
	endtask

	// 17 bit offset in three bytes, high byte first
	task automatic put_offset(input int at, input logic [`SPR_ROM_W-1:0] off);
		mem_models_inst.sprom[at] = {7'd0, off[16]};
		mem_models_inst.sprom[at + 1] = off[15:8];
		mem_models_inst.sprom[at + 2] = off[7:0];
	endtask

	task automatic fill_memories();
		int a;
		for (a = 0; a < (1 << `SPR_ROM_W); a++)
		begin
			lcg_state = lcg_next(lcg_state);
			mem_models_inst.sprom[a] = lcg_state[23:16];
		end
		put_offset(0, OFF_32);
		put_offset(3, OFF_16);
		put_offset(6, OFF_8);
		// Alpha bit of each entry decides opaque or transparent
		for (a = 0; a < 256; a++)
		begin
			lcg_state = lcg_next(lcg_state);
			mem_models_inst.palrom[a] = lcg_state[31:16];
		end
		for (a = 0; a < (1 << (`SPR_POS_W + 1)); a++)
		begin
			mem_models_inst.linebuf[a] = '0;
		end
	endtask

	task automatic load_scenarios();
		// slot, enable, size, mirror, palette, y, x, image
		table_rows[0] = '{"visible_16", 9'd100, 9'd10,
			'{5'd3, 1'b1, SIZE_16, 1'b0, 2'd1, 9'd130, 9'd40, 7'd5},
			'{5'd7, 1'b0, SIZE_8, 1'b0, 2'd0, 9'd133, 9'd60, 7'd2}};
		// Empty size code on the active line
		table_rows[1] = '{"mirror_8", 9'd50, 9'd120,
			'{5'd2, 1'b1, SIZE_8, 1'b1, 2'd2, 9'd80, 9'd200, 7'd9},
			'{5'd10, 1'b1, SIZE_NONE, 1'b0, 2'd1, 9'd83, 9'd210, 7'd1}};
		// Higher slot overlaps the lower one
		table_rows[2] = '{"overlap_32_16", 9'd150, 9'd300,
			'{5'd1, 1'b1, SIZE_32, 1'b0, 2'd3, 9'd170, 9'd100, 7'd3},
			'{5'd4, 1'b1, SIZE_16, 1'b1, 2'd0, 9'd180, 9'd108, 7'd11}};
		// One just below the line, one just above
		table_rows[3] = '{"miss_line", 9'd20, 9'd5,
			'{5'd0, 1'b1, SIZE_16, 1'b0, 2'd1, 9'd54, 9'd30, 7'd4},
			'{5'd5, 1'b1, SIZE_8, 1'b0, 2'd2, 9'd45, 9'd70, 7'd6}};
		// Active line wraps to the border, x wraps past 511
		table_rows[4] = '{"vcnt_wrap", 9'd255, 9'd200,
			'{5'd6, 1'b1, SIZE_32, 1'b0, 2'd0, 9'd500, 9'd10, 7'd1},
			'{5'd31, 1'b1, SIZE_16, 1'b0, 2'd1, 9'd20, 9'd500, 7'd20}};
	endtask

	task automatic load_record(input spr_rec_t s);
		int base;
		base = s.slot * `SPR_REC_BYTES;
		mem_models_inst.spriteram[base] = {s.enable, 1'b0, s.palette, s.size, s.mirror, s.y[8]};
		mem_models_inst.spriteram[base + 1] = s.y[7:0];
		mem_models_inst.spriteram[base + 2] = {s.image, s.x[8]};
		mem_models_inst.spriteram[base + 3] = s.x[7:0];
	endtask

	// Expected fetch start and opaque writes of one sprite
	task automatic render_sprite(input spr_rec_t s, input logic [`SPR_POS_W-1:0] active_y);
		int w;
		int i;
		logic [`SPR_POS_W:0]   y_end;
		logic [`SPR_POS_W-1:0] line;
		logic [`SPR_ROM_W-1:0] base;
		logic [`SPR_ROM_W-1:0] rom_addr;
		logic [4:0]            colour;
		lb_pixel_t             pix;
		lb_write_t             wr;
		if (!s.enable || s.size == SIZE_NONE)
		begin
			return;
		end
		w = (s.size == SIZE_32) ? 32 : (s.size == SIZE_16) ? 16 : 8;
		y_end = {1'b0, s.y} + `SPR_POS_W'(w - 1);
		if (active_y < s.y || {1'b0, active_y} > y_end)
		begin
			return;
		end
		line = active_y - s.y;
		base = (s.size == SIZE_32) ? OFF_32 : (s.size == SIZE_16) ? OFF_16 : OFF_8;
		base = base + s.image * w * w + line * w;
		exp_fetch.push_back(s.mirror ? base + w - 1 : base);
		for (i = 0; i < w; i++)
		begin
			rom_addr = s.mirror ? base + w - 1 - i : base + i;
			colour = mem_models_inst.sprom[rom_addr][4:0];
			pix = mem_models_inst.palrom[{s.palette, colour, 1'b0}];
			if (pix.alpha)
			begin
				wr.addr = {exp_wr_slot, `SPR_POS_W'(s.x + i)};
				wr.pix = pix;
				exp_writes.push_back(wr);
			end
		end
	endtask

	// Load address sequence 0 to 8 up to table_ready
	task automatic check_table_load();
		logic [`SPR_ROM_W-1:0] last_addr;
		int steps;
		int cycles;
		check_addr("table_first_addr", '0, sprom_addr);
		last_addr = sprom_addr;
		steps = 0;
		cycles = 0;
		while (!sprite_engine_inst.table_ready)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT)
			begin
				report_error("timeout waiting for the offset table load to finish");
			end
			if (sprom_addr !== last_addr)
			begin
				steps++;
				check_addr("table_addr", `SPR_ROM_W'(steps), sprom_addr);
				last_addr = sprom_addr;
			end
		end
		check_count("table_addr_steps", `SPR_TABLE_BYTES - 1, steps);
	endtask

	// One hsync edge, then wait until the scan is back in idle
	task automatic run_line(input logic [`SPR_POS_W-1:0] v);
		int cycles;
		vcnt = v;
		hsync = 1'b1;
		@(negedge clk);
		hsync = 1'b0;
		cycles = 0;
		while (sprite_engine_inst.sprite_attr_decode_inst.state != DEC_IDLE)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT)
			begin
				report_error("timeout waiting for the sprite scan to finish the line");
			end
		end
	endtask

	task automatic wait_rd_strobe();
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge clk);
			cycles++;
			if (cycles > 8)
			begin
				report_error("line buffer read strobe did not appear");
			end
		end
		while (!lb_rd_wr);
	endtask

	// Known value in the read slot, checked at the next output sample
	task automatic check_read_path(input string name, input logic [`SPR_POS_W-1:0] h);
		lb_pixel_t           value;
		logic [`SPR_POS_W:0] rd_addr;
		int                  gap;
		hcnt = h;
		rd_addr = {~exp_wr_slot, `SPR_POS_W'(h + `SPR_BORDER)};
		wait_rd_strobe();
		check_addr({name, "_rd_addr"}, `SPR_ROM_W'(rd_addr), `SPR_ROM_W'(lb_rd_addr));
		// Entry was cleared on the last edge, write after it
		@(negedge clk);
		lcg_state = lcg_next(lcg_state);
		value = lcg_state[31:16];
		mem_models_inst.linebuf[rd_addr] = value;
		gap = 1;
		while (!lb_rd_wr)
		begin
			@(negedge clk);
			gap++;
			if (gap > 8)
			begin
				report_error("line buffer read strobe stopped");
			end
		end
		check_count({name, "_rd_period"}, 4, gap);
		check_rgb({name, "_pixel_out"}, expand_colour(value), pixel_out);
	endtask

	task automatic compare_line(input string name);
		int        i;
		int        j;
		int        last;
		lb_write_t e;
		check_count({name, "_writes"}, exp_writes.size(), got_writes.size());
		for (i = 0; i < exp_writes.size(); i++)
		begin
			check_pixel(name, exp_writes[i].addr, exp_writes[i].pix,
				got_writes[i].addr, got_writes[i].pix);
		end
		check_count({name, "_fetches"}, exp_fetch.size(), got_fetch.size());
		for (i = 0; i < exp_fetch.size(); i++)
		begin
			check_addr({name, "_fetch"}, exp_fetch[i], got_fetch[i]);
		end
		// Last write to an address is what stays in the buffer
		for (i = 0; i < exp_writes.size(); i++)
		begin
			last = i;
			for (j = i + 1; j < exp_writes.size(); j++)
			begin
				if (exp_writes[j].addr == exp_writes[i].addr)
				begin
					last = j;
				end
			end
			if (last == i)
			begin
				e = exp_writes[i];
				check_pixel({name, "_final"}, e.addr, e.pix, e.addr,
					mem_models_inst.linebuf[e.addr]);
			end
		end
	endtask

	task automatic run_row(input scen_t row);
		int                    a;
		logic [`SPR_POS_W-1:0] active_y;
		for (a = 0; a < (1 << `SPR_RAM_W); a++)
		begin
			mem_models_inst.spriteram[a] = 8'h00;
		end
		load_record(row.spr_a);
		load_record(row.spr_b);
		got_writes.delete();
		exp_writes.delete();
		got_fetch.delete();
		exp_fetch.delete();
		// Write slot toggles on every hsync edge
		exp_wr_slot = ~exp_wr_slot;
		if (row.vcnt == `SPR_VCNT_WRAP)
		begin
			active_y = `SPR_BORDER;
		end
		else
		begin
			active_y = row.vcnt + `SPR_BORDER + 1;
		end
		render_sprite(row.spr_a, active_y);
		render_sprite(row.spr_b, active_y);
		run_line(row.vcnt);
		// Still before the next hsync, so late writes are caught too
		check_read_path(row.name, row.hcnt);
		compare_line(row.name);
	endtask

	// Bus monitor for writes and first fetch addresses
	always @(negedge clk)
	begin
		if (!reset && lb_wr)
		begin
			if (lb_wr_addr[`SPR_POS_W] === lb_rd_addr[`SPR_POS_W])
			begin
				report_error("write slot and read slot are the same during a write");
			end
			got_writes.push_back('{lb_wr_addr, lb_wr_data});
		end
		if (fetch_pending)
		begin
			got_fetch.push_back(sprom_addr);
		end
		fetch_pending = !reset && sprite_engine_inst.sprite_start;
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		hsync = 1'b0;
		vcnt = '0;
		hcnt = '0;
		fetch_pending = 1'b0;
		exp_wr_slot = 1'b1;
		error_count = 0;
		lcg_state = 32'h3378_e2d9;
		load_scenarios();
		fill_memories();
		repeat (10) @(negedge clk);
		reset = 1'b0;
		check_table_load();
		for (r = 0; r < NUM_ROWS; r++)
		begin
			run_row(table_rows[r]);
		end
		if (error_count == 0)
		begin
			$display("Test OK");
			$finish;
		end
		else
		begin
			$display("Test FAILED");
			$fatal(1, "errors were found");
		end
	end

endmodule

// ==== verification/sprite_mem_models.sv ====
`timescale 1ns/100ps
`include "sprite_config.svh"

module sprite_mem_models (
	input  logic                   clk,
	input  logic [`SPR_RAM_W-1:0]  spriteram_addr,
	output logic [7:0]             spriteram_data,
	input  logic [`SPR_ROM_W-1:0]  sprom_addr,
	output logic [7:0]             sprom_data,
	input  logic [7:0]             palrom_addr,
	output sprite_pkg::lb_pixel_t  palrom_data,
	input  logic [`SPR_POS_W:0]    lb_rd_addr,
	input  logic                   lb_rd_wr,
	output sprite_pkg::lb_pixel_t  lb_rd_data,
	input  logic [`SPR_POS_W:0]    lb_wr_addr,
	input  logic                   lb_wr,
	input  sprite_pkg::lb_pixel_t  lb_wr_data
);
	import sprite_pkg::*;

	// Contents are loaded by the testbench through hierarchical access
	logic [7:0] spriteram [0:(1 << `SPR_RAM_W) - 1];
	logic [7:0] sprom [0:(1 << `SPR_ROM_W) - 1];
	lb_pixel_t  palrom [0:255];
	lb_pixel_t  linebuf [0:(1 << (`SPR_POS_W + 1)) - 1];

	// Defined read data before the first clock edge
	initial
	begin
		spriteram_data = '0;
		sprom_data = '0;
		palrom_data = '0;
		lb_rd_data = '0;
	end

	// All reads have one cycle of latency
	always @(posedge clk)
	begin
		spriteram_data <= spriteram[spriteram_addr];
		sprom_data <= sprom[sprom_addr];
		palrom_data <= palrom[palrom_addr];
		lb_rd_data <= linebuf[lb_rd_addr];
	end

	// Sprite pixels go to the write slot
	// Read slot entries are zeroed behind the scan
	always @(posedge clk)
	begin
		if (lb_wr)
		begin
			linebuf[lb_wr_addr] <= lb_wr_data;
		end
		if (lb_rd_wr)
		begin
			linebuf[lb_rd_addr] <= '0;
		end
	end

endmodule
